//--- link_consts.svh
`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// ring packet geometry
`define LINK_RING_BYTES 10
`define LINK_CHANNEL_WIDTH 8
`define LINK_RING_WIDTH (`LINK_RING_BYTES * `LINK_CHANNEL_WIDTH)

// routing coordinate of a flit
`define LINK_CORD_WIDTH 4

// master nodes sit this many coordinates above the client nodes
`define LINK_CORD_OFFSET 4

// last count of a calibration phase, so a phase is 33 cycles
`define LINK_PHASE_MAX 32

`endif

//--- link_pkg.sv
`default_nettype none

`include "link_consts.svh"

package link_pkg;

  // header view of an fsb ring packet
  typedef struct packed {
    logic [3:0]  destid;
    logic        cmd;
    logic [6:0]  opcode;
    logic [3:0]  srcid;
    logic [63:0] payload;
  } fsb_pkt_s;

  // one ring word, read as a header or as plain bits
  typedef union packed {
    fsb_pkt_s                      hdr;
    logic [`LINK_RING_WIDTH-1:0]   raw;
  } ring_word_u;

  typedef struct packed {
    logic [`LINK_CORD_WIDTH-1:0] cord;
    ring_word_u                  ring;
  } flit_s;

  typedef struct packed {
    logic token_reset;
    logic upstream_reset;
    logic downstream_reset;
    logic core_link_reset;
  } link_resets_s;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_TOKEN,
    PH_TOKEN_GAP,
    PH_UP,
    PH_DOWN_PULSE,
    PH_DOWN_GAP,
    PH_CORE,
    PH_DONE
  } calib_state_e;

endpackage

`default_nettype wire

//--- phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_consts.svh"

module phase_timer (
  input  logic core_clk_i,
  input  logic sync_reset_lo,
  input  logic clear_i,
  output logic phase_done_o
);

  logic [5:0] count_r;

  // free running, restarted by the sequencer at each phase change
  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo || clear_i) begin
      count_r <= 6'd0;
    end else begin
      count_r <= count_r + 6'd1;
    end
  end

  assign phase_done_o = (count_r == 6'(`LINK_PHASE_MAX));

endmodule

`default_nettype wire

//--- calib_reset_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module calib_reset_fsm (
  input  logic                   core_clk_i,
  input  logic                   sync_reset_lo,
  input  logic                   phase_done_i,
  output logic                   timer_clear_o,
  output link_pkg::link_resets_s link_resets_o,
  output logic                   calib_done_o
);

  import link_pkg::*;

  calib_state_e state_r;
  calib_state_e state_n;
  logic         advance;
  logic         upstream_reset_r;
  logic         downstream_reset_r;
  logic         core_link_reset_r;

  // PH_DONE is terminal until the next reset
  assign advance = phase_done_i && (state_r != PH_DONE);

  always_comb begin
    state_n = state_r;
    case (state_r)
      PH_IDLE:       state_n = PH_TOKEN;
      PH_TOKEN:      state_n = PH_TOKEN_GAP;
      PH_TOKEN_GAP:  state_n = PH_UP;
      PH_UP:         state_n = PH_DOWN_PULSE;
      PH_DOWN_PULSE: state_n = PH_DOWN_GAP;
      PH_DOWN_GAP:   state_n = PH_CORE;
      PH_CORE:       state_n = PH_DONE;
      default:       state_n = PH_DONE;
    endcase
  end

  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo) begin
      state_r <= PH_IDLE;
    end else if (advance) begin
      state_r <= state_n;
    end
  end

  // link resets change on entry to the phase that owns them
  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo) begin
      upstream_reset_r   <= 1'b1;
      downstream_reset_r <= 1'b0;
      core_link_reset_r  <= 1'b1;
    end else if (advance) begin
      case (state_n)
        PH_UP:         upstream_reset_r   <= 1'b0;
        PH_DOWN_PULSE: downstream_reset_r <= 1'b1;
        PH_DOWN_GAP:   downstream_reset_r <= 1'b0;
        PH_CORE:       core_link_reset_r  <= 1'b0;
        default:       ;
      endcase
    end
  end

  always_comb begin
    link_resets_o.token_reset      = (state_r == PH_TOKEN);
    link_resets_o.upstream_reset   = upstream_reset_r;
    link_resets_o.downstream_reset = downstream_reset_r;
    link_resets_o.core_link_reset  = core_link_reset_r;
  end

  // timer restarts together with every phase step
  assign timer_clear_o = advance;
  assign calib_done_o  = (state_r == PH_DONE);

endmodule

`default_nettype wire

//--- fsb_flit_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_consts.svh"

module fsb_flit_encoder #(
  parameter bit master_p = 1'b0
) (
  input  logic                 core_clk_i,
  input  logic                 sync_reset_lo,
  input  logic                 calib_done_i,
  input  logic                 node_v_i,
  input  link_pkg::ring_word_u node_data_i,
  output logic                 node_ready_o,
  output logic                 flit_v_o,
  output link_pkg::flit_s      flit_o,
  input  logic                 flit_ready_i
);

  import link_pkg::*;

  localparam logic [`LINK_CORD_WIDTH-1:0] cord_offset_lp =
    `LINK_CORD_WIDTH'(`LINK_CORD_OFFSET);

  logic  flit_v_r;
  flit_s flit_r;
  flit_s flit_n;

  // destination coordinate from the header view, wraps modulo 16
  always_comb begin
    if (master_p) begin
      flit_n.cord = node_data_i.hdr.destid + cord_offset_lp;
    end else begin
      flit_n.cord = node_data_i.hdr.destid;
    end
    flit_n.ring.raw = node_data_i.raw;
  end

  // take a new packet when empty or when the held flit leaves now
  assign node_ready_o = calib_done_i && (!flit_v_r || flit_ready_i);

  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo || !calib_done_i) begin
      flit_v_r <= 1'b0;
    end else if (node_ready_o) begin
      flit_v_r <= node_v_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (node_v_i && node_ready_o) begin
      flit_r <= flit_n;
    end
  end

  assign flit_v_o = flit_v_r;
  assign flit_o   = flit_r;

endmodule

`default_nettype wire

//--- flit_rx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module flit_rx_buffer (
  input  logic                 core_clk_i,
  input  logic                 sync_reset_lo,
  input  logic                 calib_done_i,
  input  logic                 rx_v_i,
  input  link_pkg::flit_s      rx_flit_i,
  output logic                 rx_yumi_o,
  output logic                 pkt_v_o,
  output link_pkg::ring_word_u pkt_o,
  input  logic                 pkt_ready_i
);

  import link_pkg::*;

  ring_word_u mem_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       enq;
  logic       deq;

  // accept only with a free slot, so a full buffer leaves the flit on the link
  assign rx_yumi_o = calib_done_i && rx_v_i && (count_r != 2'd2);
  assign pkt_v_o   = (count_r != 2'd0);
  assign pkt_o     = mem_r[rd_ptr_r];

  assign enq = rx_yumi_o;
  assign deq = pkt_v_o && pkt_ready_i;

  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo || !calib_done_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (enq) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (deq) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  // coordinate is no longer needed once the flit has arrived
  always_ff @(posedge core_clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= rx_flit_i.ring;
    end
  end

endmodule

`default_nettype wire

//--- link_guts_top.sv
`timescale 1ns/1ps
`default_nettype none

module link_guts_top #(
  parameter bit master_p = 1'b0
) (
  input  logic                   core_clk_i,
  input  logic                   sync_reset_lo,
  input  logic                   node_v_i,
  input  link_pkg::ring_word_u   node_data_i,
  output logic                   node_ready_o,
  output logic                   flit_v_o,
  output link_pkg::flit_s        flit_o,
  input  logic                   flit_ready_i,
  input  logic                   rx_v_i,
  input  link_pkg::flit_s        rx_flit_i,
  output logic                   rx_yumi_o,
  output logic                   pkt_v_o,
  output link_pkg::ring_word_u   pkt_o,
  input  logic                   pkt_ready_i,
  output link_pkg::link_resets_s link_resets_o,
  output logic                   core_reset_o
);

  logic phase_done;
  logic timer_clear;
  logic calib_done;

  calib_reset_fsm i_calib_fsm (
    .core_clk_i    (core_clk_i),
    .sync_reset_lo (sync_reset_lo),
    .phase_done_i  (phase_done),
    .timer_clear_o (timer_clear),
    .link_resets_o (link_resets_o),
    .calib_done_o  (calib_done)
  );

  phase_timer i_phase_timer (
    .core_clk_i    (core_clk_i),
    .sync_reset_lo (sync_reset_lo),
    .clear_i       (timer_clear),
    .phase_done_o  (phase_done)
  );

  // transmit path, held empty until calibration ends
  fsb_flit_encoder #(
    .master_p (master_p)
  ) i_encoder (
    .core_clk_i    (core_clk_i),
    .sync_reset_lo (sync_reset_lo),
    .calib_done_i  (calib_done),
    .node_v_i      (node_v_i),
    .node_data_i   (node_data_i),
    .node_ready_o  (node_ready_o),
    .flit_v_o      (flit_v_o),
    .flit_o        (flit_o),
    .flit_ready_i  (flit_ready_i)
  );

  flit_rx_buffer i_rx_buffer (
    .core_clk_i    (core_clk_i),
    .sync_reset_lo (sync_reset_lo),
    .calib_done_i  (calib_done),
    .rx_v_i        (rx_v_i),
    .rx_flit_i     (rx_flit_i),
    .rx_yumi_o     (rx_yumi_o),
    .pkt_v_o       (pkt_v_o),
    .pkt_o         (pkt_o),
    .pkt_ready_i   (pkt_ready_i)
  );

  assign core_reset_o = ~calib_done;

endmodule

`default_nettype wire

//--- link_guts_properties.sv
`timescale 1ns/1ps
`default_nettype none

module link_guts_properties (
  input logic                   core_clk_i,
  input logic                   sync_reset_lo,
  input logic                   node_ready_o,
  input logic                   flit_v_o,
  input link_pkg::flit_s        flit_o,
  input logic                   flit_ready_i,
  input logic                   rx_v_i,
  input logic                   rx_yumi_o,
  input logic                   pkt_v_o,
  input link_pkg::ring_word_u   pkt_o,
  input logic                   pkt_ready_i,
  input link_pkg::link_resets_s link_resets_o,
  input logic                   core_reset_o
);

  import link_pkg::*;

  // clock edges seen since reset release, saturating well past calibration
  logic [8:0] edge_cnt_r;

  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo) begin
      edge_cnt_r <= 9'd0;
    end else if (edge_cnt_r != 9'd300) begin
      edge_cnt_r <= edge_cnt_r + 9'd1;
    end
  end

  // 33 cycles per phase, phase 0 is idle
  function automatic link_resets_s expected_resets(input logic [8:0] edges);
    int           phase;
    link_resets_s r;
    phase = int'(edges) / 33;
    r.token_reset      = (phase == 1);
    r.upstream_reset   = (phase < 3);
    r.downstream_reset = (phase == 4);
    r.core_link_reset  = (phase < 6);
    return r;
  endfunction

  reset_schedule_a: assert property (@(posedge core_clk_i) disable iff (sync_reset_lo)
    link_resets_o == expected_resets(edge_cnt_r))
    else $error("link resets differ from the calibration schedule");

  core_reset_a: assert property (@(posedge core_clk_i) disable iff (sync_reset_lo)
    core_reset_o == (edge_cnt_r < 9'd231))
    else $error("core reset released at the wrong edge");

  quiet_a: assert property (@(posedge core_clk_i) disable iff (sync_reset_lo)
    core_reset_o |-> !(node_ready_o || flit_v_o || rx_yumi_o || pkt_v_o))
    else $error("handshake active while the core is still in reset");

  flit_hold_a: assert property (@(posedge core_clk_i) disable iff (sync_reset_lo)
    flit_v_o && !flit_ready_i |=> flit_v_o && $stable(flit_o))
    else $error("flit dropped or changed while waiting for ready");

  pkt_hold_a: assert property (@(posedge core_clk_i) disable iff (sync_reset_lo)
    pkt_v_o && !pkt_ready_i |=> pkt_v_o && $stable(pkt_o))
    else $error("packet dropped or changed while waiting for ready");

  yumi_a: assert property (@(posedge core_clk_i) disable iff (sync_reset_lo)
    rx_yumi_o |-> rx_v_i)
    else $error("rx flit taken while none was offered");

endmodule

bind link_guts_top link_guts_properties i_props (.*);

`default_nettype wire

//--- tb_link_guts.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_consts.svh"

module tb_link_guts;

  import link_pkg::*;

  logic         core_clk = 1'b0;
  logic         sync_reset_lo = 1'b1;
  logic         node_v = 1'b0;
  ring_word_u   node_data = '0;
  logic         flit_ready = 1'b0;
  logic         rx_v = 1'b0;
  flit_s        rx_flit = '0;
  logic         pkt_ready = 1'b0;
  logic         node_ready;
  logic         flit_v;
  flit_s        flit;
  logic         rx_yumi;
  logic         pkt_v;
  ring_word_u   pkt;
  link_resets_s link_resets;
  logic         core_reset;
  logic [31:0]  rng = 32'hcd87_5be0;
  flit_s        exp_flits[$];
  ring_word_u   exp_pkts[$];
  flit_s        exp_flit;
  ring_word_u   exp_pkt;
  int           node_count = 0;
  int           rx_count = 0;
  int           node_seen = 0;
  int           rx_seen = 0;
  int           start;

  always #5 core_clk = ~core_clk;

  link_guts_top #(
    .master_p (1'b1)
  ) i_dut (
    .core_clk_i    (core_clk),
    .sync_reset_lo (sync_reset_lo),
    .node_v_i      (node_v),
    .node_data_i   (node_data),
    .node_ready_o  (node_ready),
    .flit_v_o      (flit_v),
    .flit_o        (flit),
    .flit_ready_i  (flit_ready),
    .rx_v_i        (rx_v),
    .rx_flit_i     (rx_flit),
    .rx_yumi_o     (rx_yumi),
    .pkt_v_o       (pkt_v),
    .pkt_o         (pkt),
    .pkt_ready_i   (pkt_ready),
    .link_resets_o (link_resets),
    .core_reset_o  (core_reset)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic random_word(output logic [`LINK_RING_WIDTH-1:0] w);
    rng = xorshift32(rng);
    w[31:0] = rng;
    rng = xorshift32(rng);
    w[63:32] = rng;
    rng = xorshift32(rng);
    w[79:64] = rng[15:0];
  endtask

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // a valid stays up with the same data until the DUT has taken it
  task automatic drive_traffic(input int cycles, input bit force_valid, input bit random_ready);
    logic [`LINK_RING_WIDTH-1:0] w;
    repeat (cycles) begin
      @(negedge core_clk);
      if (!node_v || node_count != node_seen) begin
        rng = xorshift32(rng);
        node_v = force_valid | rng[0];
        random_word(w);
        node_data.raw = w;
      end
      if (!rx_v || rx_count != rx_seen) begin
        rng = xorshift32(rng);
        rx_v = force_valid | rng[1];
        rx_flit.cord = rng[7:4];
        random_word(w);
        rx_flit.ring.raw = w;
      end
      node_seen = node_count;
      rx_seen = rx_count;
      if (random_ready) begin
        rng = xorshift32(rng);
        flit_ready = rng[2];
        pkt_ready = rng[3];
      end
    end
  endtask

  task automatic drain_all();
    int n;
    n = 0;
    flit_ready = 1'b1;
    pkt_ready = 1'b1;
    while (node_v || rx_v || exp_flits.size() != 0 || exp_pkts.size() != 0) begin
      if (n == 200) stop_on_error("data paths did not drain in time");
      else begin
        @(negedge core_clk);
        if (node_count != node_seen) node_v = 1'b0;
        if (rx_count != rx_seen) rx_v = 1'b0;
        node_seen = node_count;
        rx_seen = rx_count;
        n++;
      end
    end
  endtask

  // scoreboard, sampled on the edge where each transfer happens
  always @(posedge core_clk) begin
    if (!sync_reset_lo) begin
      if (flit_v && flit_ready) begin
        if (exp_flits.size() == 0) stop_on_error("flit sent with no node packet outstanding");
        else begin
          exp_flit = exp_flits.pop_front();
          assert (flit == exp_flit)
            else stop_on_error($sformatf("FAILED flit_o got %h expected %h", flit, exp_flit));
        end
      end
      if (node_v && node_ready) begin
        exp_flit.cord = node_data.raw[`LINK_RING_WIDTH-1 -: `LINK_CORD_WIDTH]
          + 4'(`LINK_CORD_OFFSET);
        exp_flit.ring = node_data;
        exp_flits.push_back(exp_flit);
        node_count++;
      end
      if (pkt_v && pkt_ready) begin
        if (exp_pkts.size() == 0) stop_on_error("packet delivered with no flit outstanding");
        else begin
          exp_pkt = exp_pkts.pop_front();
          assert (pkt == exp_pkt)
            else stop_on_error($sformatf("FAILED pkt_o got %h expected %h", pkt, exp_pkt));
        end
      end
      if (rx_v && rx_yumi) begin
        exp_pkts.push_back(rx_flit.ring);
        rx_count++;
      end
    end
  end

  initial begin
    int n;
    repeat (16) @(negedge core_clk);
    sync_reset_lo = 1'b0;
    // offer on both paths during calibration, nothing may be taken
    node_v = 1'b1;
    rx_v = 1'b1;
    flit_ready = 1'b1;
    pkt_ready = 1'b1;
    n = 0;
    while (core_reset) begin
      if (n == 400) stop_on_error("core reset was never released");
      else begin
        @(negedge core_clk);
        n++;
      end
    end
    drive_traffic(300, 1'b0, 1'b1);
    drain_all();
    // rx buffer fills to two entries, then the flit waits on the link
    pkt_ready = 1'b0;
    start = rx_count;
    drive_traffic(12, 1'b1, 1'b0);
    assert (rx_count - start == 2)
      else stop_on_error($sformatf("FAILED rx_yumi_o accepts got %h expected %h",
                                   rx_count - start, 2));
    drain_all();
    // encoder holds a single flit
    flit_ready = 1'b0;
    start = node_count;
    drive_traffic(12, 1'b1, 1'b0);
    assert (node_count - start == 1)
      else stop_on_error($sformatf("FAILED node_ready_o accepts got %h expected %h",
                                   node_count - start, 1));
    drain_all();
    if (exp_flits.size() == 0 && exp_pkts.size() == 0 && node_count > 0 && rx_count > 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_on_error("traffic missing or left in the scoreboards at the end");
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
link_pkg.sv
phase_timer.sv
calib_reset_fsm.sv
fsb_flit_encoder.sv
flit_rx_buffer.sv
link_guts_top.sv
link_guts_properties.sv
tb_link_guts.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_link_guts
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
